//--- sim.f
smartnic_demux_pkg.sv
port_demux.sv
pkt_fifo.sv
egr_mux.sv
egr_demux.sv
smartnic_demux.sv
tb_smartnic_demux.sv

//--- run_sim.sh
#!/bin/sh
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_smartnic_demux -f sim.f \
    || exit 1
./obj_dir/Vtb_smartnic_demux > sim.log 2>&1
cat sim.log
grep -q "CHECKS FAILED" sim.log && exit 1 || grep -q "ALL CHECKS PASSED" sim.log || exit 1
exit 0

//--- tb_smartnic_demux.sv
`timescale 1ns/1ns

module tb_smartnic_demux;
    localparam int DW             = smartnic_demux_pkg::DATA_WID;
    localparam int PW             = smartnic_demux_pkg::PORT_WID;
    localparam int NP             = smartnic_demux_pkg::NUM_PORT;
    localparam int NSRC           = 2 * NP;  // Bypass sources first, then app sources.
    localparam int PKTS_PER_PHASE = 20;
    localparam int NUM_PHASE      = 3;
    localparam int MAX_CYCLES     = 200000;
    localparam logic [NP-1:0] PHASE_SEL [NUM_PHASE] = '{2'b00, 2'b11, 2'b10};

    logic          core_clk = 1'b0;
    logic          srst;
    logic [NP-1:0] bypass_to_core_tvalid;
    logic [NP-1:0] bypass_to_core_tready;
    logic [DW-1:0] bypass_to_core_tdata [NP];
    logic [NP-1:0] bypass_to_core_tlast;
    logic [PW-1:0] bypass_to_core_tid [NP];
    logic [PW-1:0] bypass_to_core_tdest [NP];
    logic [NP-1:0] app_to_core_tvalid;
    logic [NP-1:0] app_to_core_tready;
    logic [DW-1:0] app_to_core_tdata [NP];
    logic [NP-1:0] app_to_core_tlast;
    logic [PW-1:0] app_to_core_tid [NP];
    logic [PW-1:0] app_to_core_tdest [NP];
    logic [NP-1:0] core_to_cmac_tvalid;
    logic [NP-1:0] core_to_cmac_tready = '0;
    logic [DW-1:0] core_to_cmac_tdata [NP];
    logic [NP-1:0] core_to_cmac_tlast;
    logic [PW-1:0] core_to_cmac_tid [NP];
    logic [PW-1:0] core_to_cmac_tdest [NP];
    logic [NP-1:0] core_to_host_tvalid;
    logic [NP-1:0] core_to_host_tready = '0;
    logic [DW-1:0] core_to_host_tdata [NP];
    logic [NP-1:0] core_to_host_tlast;
    logic [PW-1:0] core_to_host_tid [NP];
    logic [PW-1:0] core_to_host_tdest [NP];
    logic [NP-1:0] out_sel;

    logic [DW+2*PW:0] exp_q [NSRC*NP][$];  // Entry is {tdest, tid, last, data}.
    logic [NP-1:0]    in_pkt = '0;
    int               cur_src [NP];
    int               cycle_cnt = 0;

    smartnic_demux #(
        .FIFO_DEPTH (64),
        .FIFO_PKTS  (8)
    ) u_dut (.*);

    always #2 core_clk = !core_clk;

    always @(posedge core_clk) begin
        cycle_cnt++;
        if (cycle_cnt == MAX_CYCLES) begin
            $display("Timeout: traffic did not drain within %0d cycles", MAX_CYCLES);
            $display("CHECKS FAILED");
            $fatal(1);
        end
    end

    always @(negedge core_clk) begin
        for (int p = 0; p < NP; p++) begin
            core_to_cmac_tready[p] = ($urandom % 4) != 0;
            core_to_host_tready[p] = ($urandom % 4) != 0;
        end
    end

    task automatic stop_on_error(input string msg);
        $display("Fail at %0t ns: %s", $time, msg);
        $display("CHECKS FAILED");
        $fatal(1);
    endtask

    task automatic set_source(input int src, input logic valid, input logic [DW-1:0] data,
                              input logic last, input logic [PW-1:0] tid,
                              input logic [PW-1:0] tdest);
        if (src < NP) begin
            bypass_to_core_tvalid[src] = valid;
            bypass_to_core_tdata[src]  = data;
            bypass_to_core_tlast[src]  = last;
            bypass_to_core_tid[src]    = tid;
            bypass_to_core_tdest[src]  = tdest;
        end else begin
            app_to_core_tvalid[src-NP] = valid;
            app_to_core_tdata[src-NP]  = data;
            app_to_core_tlast[src-NP]  = last;
            app_to_core_tid[src-NP]    = tid;
            app_to_core_tdest[src-NP]  = tdest;
        end
    endtask

    function automatic logic source_ready(input int src);
        return (src < NP) ? bypass_to_core_tready[src] : app_to_core_tready[src-NP];
    endfunction

    function automatic int pending_words();
        int total;
        total = 0;
        for (int i = 0; i < NSRC * NP; i++) begin
            total += exp_q[i].size();
        end
        return total;
    endfunction

    task automatic run_source(input int src, input int phase);
        int            len;
        int            dst;
        logic          last;
        logic [PW-1:0] tid;
        logic [PW-1:0] tdest;
        logic [DW-1:0] data;
        for (int n = 0; n < PKTS_PER_PHASE; n++) begin
            len   = 1 + int'($urandom % 12);
            tid   = PW'($urandom);
            tdest = PW'($urandom);
            dst   = (src < NP) ? src : int'(tdest[0]);  // Bypass stays on its own port.
            for (int w = 0; w < len; w++) begin
                while ($urandom % 4 == 0) begin
                    @(negedge core_clk);
                end
                last = (w == len - 1);
                data = {8'hc5, 8'(src), 16'(phase * PKTS_PER_PHASE + n), 16'(w), 16'(len)};
                exp_q[src*NP+dst].push_back({tdest, tid, last, data});
                set_source(src, 1'b1, data, last, tid, tdest);
                @(posedge core_clk);
                while (!source_ready(src)) begin
                    @(posedge core_clk);
                end
                @(negedge core_clk);
                set_source(src, 1'b0, data, last, tid, tdest);
            end
        end
    endtask

    task automatic check_word(input int port, input logic side, input logic [DW-1:0] data,
                              input logic last, input logic [PW-1:0] tid,
                              input logic [PW-1:0] tdest);
        int               src;
        logic [DW+2*PW:0] exp;
        src = int'(data[55:48]);
        assert (side == out_sel[port])
            else stop_on_error($sformatf("port %0d word on side %0d, select is %0d",
                                         port, side, out_sel[port]));
        assert (src < NSRC)
            else stop_on_error($sformatf("port %0d word %h has no valid source", port, data));
        assert (!in_pkt[port] || src == cur_src[port])
            else stop_on_error($sformatf("port %0d source %0d cut into a packet of %0d",
                                         port, src, cur_src[port]));
        assert (exp_q[src*NP+port].size() != 0)
            else stop_on_error($sformatf("port %0d extra word %h", port, data));
        exp = exp_q[src*NP+port].pop_front();
        assert ({tdest, tid, last, data} == exp)
            else stop_on_error($sformatf("port %0d got %h expected %h",
                                         port, {tdest, tid, last, data}, exp));
        in_pkt[port]  = !last;
        cur_src[port] = src;
    endtask

    task automatic check_idle(input string when);
        assert ((core_to_cmac_tvalid | core_to_host_tvalid) == '0)
            else stop_on_error($sformatf("output tvalid high %s", when));
    endtask

    // Outputs are read at the rising edge, before any register update.
    always @(posedge core_clk) begin
        if (!srst) begin
            for (int p = 0; p < NP; p++) begin
                if (core_to_cmac_tvalid[p] && core_to_cmac_tready[p]) begin
                    check_word(p, 1'b0, core_to_cmac_tdata[p], core_to_cmac_tlast[p],
                               core_to_cmac_tid[p], core_to_cmac_tdest[p]);
                end
                if (core_to_host_tvalid[p] && core_to_host_tready[p]) begin
                    check_word(p, 1'b1, core_to_host_tdata[p], core_to_host_tlast[p],
                               core_to_host_tid[p], core_to_host_tdest[p]);
                end
            end
        end
    end

    initial begin
        void'($urandom(32'hd1ce));
        srst    = 1'b1;
        out_sel = PHASE_SEL[0];
        for (int s = 0; s < NSRC; s++) begin
            set_source(s, 1'b0, '0, 1'b0, '0, '0);
        end
        for (int c = 0; c < 5; c++) begin
            @(posedge core_clk);
            if (c > 0) begin
                check_idle("during reset");
            end
        end
        @(negedge core_clk);
        srst = 1'b0;
        @(posedge core_clk);
        check_idle("in the first cycle after reset");
        @(negedge core_clk);
        for (int ph = 0; ph < NUM_PHASE; ph++) begin
            out_sel = PHASE_SEL[ph];  // Egress is idle here.
            fork
                run_source(0, ph);
                run_source(1, ph);
                run_source(2, ph);
                run_source(3, ph);
            join
            while (pending_words() != 0) begin
                @(negedge core_clk);
            end
        end
        repeat (20) @(posedge core_clk);  // Catch stray words.
        if (pending_words() == 0 && (core_to_cmac_tvalid | core_to_host_tvalid) == '0) begin
            $display("ALL CHECKS PASSED");
            $finish;
        end else begin
            $display("Traffic left over at the end of the run");
            $display("CHECKS FAILED");
            $fatal(1);
        end
    end

endmodule

//--- smartnic_demux.sv
`timescale 1ns/1ns

module smartnic_demux #(
    parameter int FIFO_DEPTH = 64,
    parameter int FIFO_PKTS  = 8
) (
    input  logic                                    core_clk,
    input  logic                                    srst,
    input  logic [smartnic_demux_pkg::NUM_PORT-1:0] bypass_to_core_tvalid,
    output logic [smartnic_demux_pkg::NUM_PORT-1:0] bypass_to_core_tready,
    input  logic [smartnic_demux_pkg::DATA_WID-1:0] bypass_to_core_tdata [smartnic_demux_pkg::NUM_PORT],
    input  logic [smartnic_demux_pkg::NUM_PORT-1:0] bypass_to_core_tlast,
    input  logic [smartnic_demux_pkg::PORT_WID-1:0] bypass_to_core_tid [smartnic_demux_pkg::NUM_PORT],
    input  logic [smartnic_demux_pkg::PORT_WID-1:0] bypass_to_core_tdest [smartnic_demux_pkg::NUM_PORT],
    input  logic [smartnic_demux_pkg::NUM_PORT-1:0] app_to_core_tvalid,
    output logic [smartnic_demux_pkg::NUM_PORT-1:0] app_to_core_tready,
    input  logic [smartnic_demux_pkg::DATA_WID-1:0] app_to_core_tdata [smartnic_demux_pkg::NUM_PORT],
    input  logic [smartnic_demux_pkg::NUM_PORT-1:0] app_to_core_tlast,
    input  logic [smartnic_demux_pkg::PORT_WID-1:0] app_to_core_tid [smartnic_demux_pkg::NUM_PORT],
    input  logic [smartnic_demux_pkg::PORT_WID-1:0] app_to_core_tdest [smartnic_demux_pkg::NUM_PORT],
    output logic [smartnic_demux_pkg::NUM_PORT-1:0] core_to_cmac_tvalid,
    input  logic [smartnic_demux_pkg::NUM_PORT-1:0] core_to_cmac_tready,
    output logic [smartnic_demux_pkg::DATA_WID-1:0] core_to_cmac_tdata [smartnic_demux_pkg::NUM_PORT],
    output logic [smartnic_demux_pkg::NUM_PORT-1:0] core_to_cmac_tlast,
    output logic [smartnic_demux_pkg::PORT_WID-1:0] core_to_cmac_tid [smartnic_demux_pkg::NUM_PORT],
    output logic [smartnic_demux_pkg::PORT_WID-1:0] core_to_cmac_tdest [smartnic_demux_pkg::NUM_PORT],
    output logic [smartnic_demux_pkg::NUM_PORT-1:0] core_to_host_tvalid,
    input  logic [smartnic_demux_pkg::NUM_PORT-1:0] core_to_host_tready,
    output logic [smartnic_demux_pkg::DATA_WID-1:0] core_to_host_tdata [smartnic_demux_pkg::NUM_PORT],
    output logic [smartnic_demux_pkg::NUM_PORT-1:0] core_to_host_tlast,
    output logic [smartnic_demux_pkg::PORT_WID-1:0] core_to_host_tid [smartnic_demux_pkg::NUM_PORT],
    output logic [smartnic_demux_pkg::PORT_WID-1:0] core_to_host_tdest [smartnic_demux_pkg::NUM_PORT],
    input  logic [smartnic_demux_pkg::NUM_PORT-1:0] out_sel
);
    localparam int NP = smartnic_demux_pkg::NUM_PORT;
    localparam int NS = smartnic_demux_pkg::NUM_SRC;
    localparam int DW = smartnic_demux_pkg::DATA_WID;
    localparam int PW = smartnic_demux_pkg::PORT_WID;
    localparam int SB = smartnic_demux_pkg::SRC_BYPASS;
    localparam int S0 = smartnic_demux_pkg::SRC_PORT0;

    logic [NP-1:0] dmx_valid [NP];
    logic [NP-1:0] dmx_ready [NP];
    logic [DW-1:0] dmx_data  [NP];
    logic [NP-1:0] dmx_last;
    logic [PW-1:0] dmx_tid   [NP];
    logic [PW-1:0] dmx_tdest [NP];

    logic [NS-1:0] mux_valid [NP];
    logic [NS-1:0] mux_ready [NP];
    logic [DW-1:0] mux_data  [NP][NS];
    logic [NS-1:0] mux_last  [NP];
    logic [PW-1:0] mux_tid   [NP][NS];
    logic [PW-1:0] mux_tdest [NP][NS];

    logic [NP-1:0] mrg_valid;
    logic [NP-1:0] mrg_ready;
    logic [DW-1:0] mrg_data  [NP];
    logic [NP-1:0] mrg_last;
    logic [PW-1:0] mrg_tid   [NP];
    logic [PW-1:0] mrg_tdest [NP];

    for (genvar i = 0; i < NP; i++) begin : g_port
        port_demux u_port_demux (
            .core_clk  (core_clk),
            .srst      (srst),
            .in_valid  (app_to_core_tvalid[i]),
            .in_ready  (app_to_core_tready[i]),
            .in_data   (app_to_core_tdata[i]),
            .in_last   (app_to_core_tlast[i]),
            .in_tid    (app_to_core_tid[i]),
            .in_tdest  (app_to_core_tdest[i]),
            .out_valid (dmx_valid[i]),
            .out_ready (dmx_ready[i]),
            .out_data  (dmx_data[i]),
            .out_last  (dmx_last[i]),
            .out_tid   (dmx_tid[i]),
            .out_tdest (dmx_tdest[i])
        );

        // Bypass goes straight to its own egress arbiter.
        assign mux_valid[i][SB]       = bypass_to_core_tvalid[i];
        assign bypass_to_core_tready[i] = mux_ready[i][SB];
        assign mux_data[i][SB]        = bypass_to_core_tdata[i];
        assign mux_last[i][SB]        = bypass_to_core_tlast[i];
        assign mux_tid[i][SB]         = bypass_to_core_tid[i];
        assign mux_tdest[i][SB]       = bypass_to_core_tdest[i];

        // Crossed wiring. Ingress i lands on arbiter input S0 + i of egress j.
        for (genvar j = 0; j < NP; j++) begin : g_fifo
            pkt_fifo #(
                .FIFO_DEPTH (FIFO_DEPTH),
                .FIFO_PKTS  (FIFO_PKTS)
            ) u_fifo (
                .core_clk  (core_clk),
                .srst      (srst),
                .in_valid  (dmx_valid[i][j]),
                .in_ready  (dmx_ready[i][j]),
                .in_data   (dmx_data[i]),
                .in_last   (dmx_last[i]),
                .in_tid    (dmx_tid[i]),
                .in_tdest  (dmx_tdest[i]),
                .out_valid (mux_valid[j][S0 + i]),
                .out_ready (mux_ready[j][S0 + i]),
                .out_data  (mux_data[j][S0 + i]),
                .out_last  (mux_last[j][S0 + i]),
                .out_tid   (mux_tid[j][S0 + i]),
                .out_tdest (mux_tdest[j][S0 + i])
            );
        end

        egr_mux u_egr_mux (
            .core_clk  (core_clk),
            .srst      (srst),
            .in_valid  (mux_valid[i]),
            .in_ready  (mux_ready[i]),
            .in_data   (mux_data[i]),
            .in_last   (mux_last[i]),
            .in_tid    (mux_tid[i]),
            .in_tdest  (mux_tdest[i]),
            .out_valid (mrg_valid[i]),
            .out_ready (mrg_ready[i]),
            .out_data  (mrg_data[i]),
            .out_last  (mrg_last[i]),
            .out_tid   (mrg_tid[i]),
            .out_tdest (mrg_tdest[i])
        );

        egr_demux u_egr_demux (
            .core_clk   (core_clk),
            .srst       (srst),
            .out_sel    (out_sel[i]),
            .in_valid   (mrg_valid[i]),
            .in_ready   (mrg_ready[i]),
            .in_data    (mrg_data[i]),
            .in_last    (mrg_last[i]),
            .in_tid     (mrg_tid[i]),
            .in_tdest   (mrg_tdest[i]),
            .cmac_valid (core_to_cmac_tvalid[i]),
            .cmac_ready (core_to_cmac_tready[i]),
            .cmac_data  (core_to_cmac_tdata[i]),
            .cmac_last  (core_to_cmac_tlast[i]),
            .cmac_tid   (core_to_cmac_tid[i]),
            .cmac_tdest (core_to_cmac_tdest[i]),
            .host_valid (core_to_host_tvalid[i]),
            .host_ready (core_to_host_tready[i]),
            .host_data  (core_to_host_tdata[i]),
            .host_last  (core_to_host_tlast[i]),
            .host_tid   (core_to_host_tid[i]),
            .host_tdest (core_to_host_tdest[i])
        );
    end

endmodule

//--- egr_demux.sv
`timescale 1ns/1ns

module egr_demux (
    input  logic                                    core_clk,
    input  logic                                    srst,
    input  logic                                    out_sel,
    input  logic                                    in_valid,
    output logic                                    in_ready,
    input  logic [smartnic_demux_pkg::DATA_WID-1:0] in_data,
    input  logic                                    in_last,
    input  logic [smartnic_demux_pkg::PORT_WID-1:0] in_tid,
    input  logic [smartnic_demux_pkg::PORT_WID-1:0] in_tdest,
    output logic                                    cmac_valid,
    input  logic                                    cmac_ready,
    output logic [smartnic_demux_pkg::DATA_WID-1:0] cmac_data,
    output logic                                    cmac_last,
    output logic [smartnic_demux_pkg::PORT_WID-1:0] cmac_tid,
    output logic [smartnic_demux_pkg::PORT_WID-1:0] cmac_tdest,
    output logic                                    host_valid,
    input  logic                                    host_ready,
    output logic [smartnic_demux_pkg::DATA_WID-1:0] host_data,
    output logic                                    host_last,
    output logic [smartnic_demux_pkg::PORT_WID-1:0] host_tid,
    output logic [smartnic_demux_pkg::PORT_WID-1:0] host_tdest
);
    logic busy;
    logic sel_q;
    logic sel;

    assign sel = busy ? sel_q : out_sel;  // Live select on the first word only.

    assign cmac_valid = in_valid && !sel;
    assign host_valid = in_valid && sel;
    assign in_ready   = sel ? host_ready : cmac_ready;

    assign cmac_data  = in_data;
    assign cmac_last  = in_last;
    assign cmac_tid   = in_tid;
    assign cmac_tdest = in_tdest;
    assign host_data  = in_data;
    assign host_last  = in_last;
    assign host_tid   = in_tid;
    assign host_tdest = in_tdest;

    always_ff @(posedge core_clk) begin
        if (srst) begin
            busy  <= 1'b0;
            sel_q <= 1'b0;
        end else if (in_valid && in_ready) begin
            busy <= !in_last;
            if (!busy) begin
                sel_q <= out_sel;
            end
        end
    end

    // Side stays fixed from the first word until tlast.
    a_sel_hold: assert property (@(posedge core_clk) disable iff (srst)
        (in_valid && in_ready && !in_last) |=> (sel == $past(sel)));

endmodule

//--- egr_mux.sv
`timescale 1ns/1ns

module egr_mux (
    input  logic                                     core_clk,
    input  logic                                     srst,
    input  logic [smartnic_demux_pkg::NUM_SRC-1:0]   in_valid,
    output logic [smartnic_demux_pkg::NUM_SRC-1:0]   in_ready,
    input  logic [smartnic_demux_pkg::DATA_WID-1:0]  in_data [smartnic_demux_pkg::NUM_SRC],
    input  logic [smartnic_demux_pkg::NUM_SRC-1:0]   in_last,
    input  logic [smartnic_demux_pkg::PORT_WID-1:0]  in_tid [smartnic_demux_pkg::NUM_SRC],
    input  logic [smartnic_demux_pkg::PORT_WID-1:0]  in_tdest [smartnic_demux_pkg::NUM_SRC],
    output logic                                     out_valid,
    input  logic                                     out_ready,
    output logic [smartnic_demux_pkg::DATA_WID-1:0]  out_data,
    output logic                                     out_last,
    output logic [smartnic_demux_pkg::PORT_WID-1:0]  out_tid,
    output logic [smartnic_demux_pkg::PORT_WID-1:0]  out_tdest
);
    localparam int NS = smartnic_demux_pkg::NUM_SRC;
    localparam int IW = $clog2(NS);

    logic          busy;
    logic [NS-1:0] grant_q;
    logic [IW-1:0] rr_q;      // Last winner, also the owner while busy.
    logic [NS-1:0] pick;
    logic [IW-1:0] pick_idx;
    logic [NS-1:0] cur_grant;
    logic [IW-1:0] cur_idx;
    logic          can_load;
    logic          accept;

    // Round robin starting after the last winner.
    always_comb begin
        int idx;
        pick     = '0;
        pick_idx = rr_q;
        for (int k = NS; k >= 1; k--) begin
            idx = (int'(rr_q) + k) % NS;
            if (in_valid[idx]) begin
                pick      = '0;
                pick[idx] = 1'b1;
                pick_idx  = IW'(idx);
            end
        end
    end

    assign cur_grant = busy ? grant_q : pick;
    assign cur_idx   = busy ? rr_q : pick_idx;
    assign can_load  = !out_valid || out_ready;
    assign in_ready  = cur_grant & {NS{can_load}};
    assign accept    = |(in_valid & in_ready);

    always_ff @(posedge core_clk) begin
        if (srst) begin
            busy      <= 1'b0;
            grant_q   <= '0;
            rr_q      <= IW'(smartnic_demux_pkg::SRC_PORT1);  // Bypass wins first.
            out_valid <= 1'b0;
        end else begin
            if (accept) begin
                busy    <= !in_last[cur_idx];
                grant_q <= in_last[cur_idx] ? '0 : cur_grant;
                rr_q    <= cur_idx;
            end
            if (accept) begin
                out_valid <= 1'b1;
            end else if (out_ready) begin
                out_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge core_clk) begin
        if (accept) begin
            out_data  <= in_data[cur_idx];
            out_last  <= in_last[cur_idx];
            out_tid   <= in_tid[cur_idx];
            out_tdest <= in_tdest[cur_idx];
        end
    end

    a_grant_onehot: assert property (@(posedge core_clk) disable iff (srst)
        $onehot0(grant_q) && (busy == (|grant_q)));

    a_out_hold: assert property (@(posedge core_clk) disable iff (srst)
        out_valid && !out_ready |=> out_valid && $stable(out_data) && $stable(out_last));

endmodule

//--- pkt_fifo.sv
`timescale 1ns/1ns

module pkt_fifo #(
    parameter int FIFO_DEPTH = 64,
    parameter int FIFO_PKTS  = 8
) (
    input  logic                                    core_clk,
    input  logic                                    srst,
    input  logic                                    in_valid,
    output logic                                    in_ready,
    input  logic [smartnic_demux_pkg::DATA_WID-1:0] in_data,
    input  logic                                    in_last,
    input  logic [smartnic_demux_pkg::PORT_WID-1:0] in_tid,
    input  logic [smartnic_demux_pkg::PORT_WID-1:0] in_tdest,
    output logic                                    out_valid,
    input  logic                                    out_ready,
    output logic [smartnic_demux_pkg::DATA_WID-1:0] out_data,
    output logic                                    out_last,
    output logic [smartnic_demux_pkg::PORT_WID-1:0] out_tid,
    output logic [smartnic_demux_pkg::PORT_WID-1:0] out_tdest
);
    localparam int AW = $clog2(FIFO_DEPTH);
    localparam int CW = $clog2(FIFO_PKTS + 1);
    localparam int WW = smartnic_demux_pkg::DATA_WID + 2 * smartnic_demux_pkg::PORT_WID + 1;

    logic [WW-1:0] mem [FIFO_DEPTH];
    logic [AW:0]   wr_ptr;
    logic [AW:0]   rd_ptr;
    logic [AW:0]   word_cnt;
    logic [CW-1:0] pkt_cnt;
    logic          wr_en;
    logic          rd_en;
    logic          pkt_in;
    logic          pkt_out;
    logic [WW-1:0] rd_word;

    assign word_cnt = wr_ptr - rd_ptr;  // Msb set only when all words are used.
    assign in_ready = !word_cnt[AW] && (pkt_cnt != CW'(FIFO_PKTS));
    assign wr_en    = in_valid && in_ready;

    // Nothing leaves until a whole packet is stored.
    assign out_valid = (pkt_cnt != '0);
    assign rd_en     = out_valid && out_ready;

    assign pkt_in  = wr_en && in_last;
    assign pkt_out = rd_en && out_last;

    assign rd_word = mem[rd_ptr[AW-1:0]];
    assign {out_tdest, out_tid, out_last, out_data} = rd_word;

    always_ff @(posedge core_clk) begin
        if (wr_en) begin
            mem[wr_ptr[AW-1:0]] <= {in_tdest, in_tid, in_last, in_data};
        end
    end

    always_ff @(posedge core_clk) begin
        if (srst) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            pkt_cnt <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (pkt_in && !pkt_out) begin
                pkt_cnt <= pkt_cnt + 1'b1;
            end else if (pkt_out && !pkt_in) begin
                pkt_cnt <= pkt_cnt - 1'b1;
            end
        end
    end

    // Every stored packet holds at least one word.
    a_pkt_words: assert property (@(posedge core_clk) disable iff (srst)
        int'(pkt_cnt) <= int'(word_cnt));

    // Packet count must never claim words the pointers do not hold.
    a_no_underflow: assert property (@(posedge core_clk) disable iff (srst)
        rd_en |-> (word_cnt != '0));

endmodule

//--- port_demux.sv
`timescale 1ns/1ns

module port_demux (
    input  logic                                    core_clk,
    input  logic                                    srst,
    input  logic                                    in_valid,
    output logic                                    in_ready,
    input  logic [smartnic_demux_pkg::DATA_WID-1:0] in_data,
    input  logic                                    in_last,
    input  logic [smartnic_demux_pkg::PORT_WID-1:0] in_tid,
    input  logic [smartnic_demux_pkg::PORT_WID-1:0] in_tdest,
    output logic [1:0]                              out_valid,
    input  logic [1:0]                              out_ready,
    output logic [smartnic_demux_pkg::DATA_WID-1:0] out_data,
    output logic                                    out_last,
    output logic [smartnic_demux_pkg::PORT_WID-1:0] out_tid,
    output logic [smartnic_demux_pkg::PORT_WID-1:0] out_tdest
);
    logic busy;
    logic dest_q;
    logic dest;

    // First word routes by tdest lsb, the rest follow the lock.
    assign dest = busy ? dest_q : in_tdest[0];

    assign out_valid[0] = in_valid && !dest;
    assign out_valid[1] = in_valid && dest;
    assign in_ready     = out_ready[dest];

    assign out_data  = in_data;
    assign out_last  = in_last;
    assign out_tid   = in_tid;
    assign out_tdest = in_tdest;

    always_ff @(posedge core_clk) begin
        if (srst) begin
            busy   <= 1'b0;
            dest_q <= 1'b0;
        end else if (in_valid && in_ready) begin
            busy <= !in_last;
            if (!busy) begin
                dest_q <= in_tdest[0];  // Lock for the rest of the packet.
            end
        end
    end

    // A packet in flight stays on the output it started on.
    a_dest_lock: assert property (@(posedge core_clk) disable iff (srst)
        (in_valid && in_ready && !in_last) |=> (dest == $past(dest)));

endmodule

//--- smartnic_demux_pkg.sv
package smartnic_demux_pkg;

    // Port count is fixed since the egress wiring is crossed.
    localparam int NUM_PORT = 2;

    // Width of tid and tdest.
    localparam int PORT_WID = 2;

    // Width of tdata.
    localparam int DATA_WID = 64;

    // Egress arbiter inputs.
    localparam int SRC_BYPASS = 0;
    localparam int SRC_PORT0  = 1;
    localparam int SRC_PORT1  = 2;
    localparam int NUM_SRC    = 3;

endpackage
